// File: Makefile
SIM   := verilator
FLAGS := --binary --timing --assert
LINT  := --lint-only --timing
TOP   := tb_dma_chan
FLIST := compile.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT) -f $(FLIST) --top-module $(TOP)

sim:
	$(SIM) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ)
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: compile.f
+incdir+hdl
hdl/dma_pkg.sv
hdl/chan_if.sv
hdl/chan_fifo.sv
hdl/dma_channel.sv
hdl/byte_swap_stage.sv
hdl/dma_chan_top.sv
sim/tb_dma_chan.sv

// File: hdl/byte_swap_stage.sv
module byte_swap_stage import dma_pkg::*; (
   input  logic      wb_clk_i,
   input  logic      rst_n_i,
   input  logic      m_reset_i,
   fifo_rd_if.reader src_rd,
   fifo_wr_if.writer dst_wr,
   output logic      pkt_end_o
);

   beat_t out_beat; // Swapped beat waiting for the destination
   logic  out_valid;
   logic  pkt_end_r;
   logic  pop;
   logic  push;

   assign push = out_valid && !dst_wr.full;

   // Refill when the register is free or draining this cycle
   assign pop = !src_rd.empty && (!out_valid || push) && !m_reset_i;

   assign src_rd.get  = pop;
   assign dst_wr.put  = push;
   assign dst_wr.beat = out_beat;
   assign pkt_end_o   = pkt_end_r;

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i || m_reset_i) begin
         out_valid <= 1'b0;
         pkt_end_r <= 1'b0;
      end else begin
         if (pop)
            out_valid <= 1'b1;
         else if (push)
            out_valid <= 1'b0;

         // A packet end leaving the stage wins over a new pop
         if (push && out_beat.last)
            pkt_end_r <= 1'b1;
         else if (pop)
            pkt_end_r <= 1'b0;
      end
   end

   // Byte order reversal with the last flag carried along
   always_ff @(posedge wb_clk_i) begin
      if (pop) begin
         out_beat.data <= {<<8{src_rd.head.data}};
         out_beat.last <= src_rd.head.last;
      end
   end

   // Source head must hold while the stage is not popping
   a_src_head_stable: assert property (
      @(posedge wb_clk_i) disable iff (!rst_n_i || m_reset_i)
      (!src_rd.empty && !src_rd.get) |=> (src_rd.empty || $stable(src_rd.head))
   ) else $error("source head changed without a pop");

endmodule

// File: hdl/chan_fifo.sv
`include "dma_params.svh"

module chan_fifo import dma_pkg::*; (
   input logic     wb_clk_i,
   input logic     rst_n_i,
   input logic     clear_i,
   fifo_wr_if.fifo wr,
   fifo_rd_if.fifo rd
);

   localparam fifo_cnt_t DEPTH = fifo_cnt_t'(2 ** `DMA_FIFO_AW);

   beat_t      mem [2 ** `DMA_FIFO_AW];
   fifo_addr_t wr_ptr;
   fifo_addr_t rd_ptr;
   fifo_cnt_t  cnt;
   fifo_cnt_t  cnt_next;
   logic       do_put;
   logic       do_get;

   logic       empty_r;
   logic       almost_empty_r;
   logic       full_r;
   logic       almost_full_r;
   logic       half_full_r;

   assign do_put = wr.put && !full_r;
   assign do_get = rd.get && !empty_r;

   always_comb begin
      case ({do_put, do_get})
         2'b10:   cnt_next = cnt + 1'b1;
         2'b01:   cnt_next = cnt - 1'b1;
         default: cnt_next = cnt; // Idle, or put and get together
      endcase
   end

   // Pointers, count and flags; a clear acts like reset
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i || clear_i) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         cnt            <= '0;
         empty_r        <= 1'b1;
         almost_empty_r <= 1'b1;
         full_r         <= 1'b0;
         almost_full_r  <= 1'b0;
         half_full_r    <= 1'b0;
      end else begin
         if (do_put)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_get)
            rd_ptr <= rd_ptr + 1'b1;
         cnt            <= cnt_next;
         // Flags follow the new count at the same edge
         empty_r        <= (cnt_next == '0);
         almost_empty_r <= (cnt_next <= fifo_cnt_t'(`DMA_ALMOST_EMPTY));
         full_r         <= (cnt_next == DEPTH);
         almost_full_r  <= (cnt_next >= fifo_cnt_t'(`DMA_ALMOST_FULL));
         half_full_r    <= (cnt_next >= fifo_cnt_t'(`DMA_HALF_FULL));
      end
   end

   // Storage
   always_ff @(posedge wb_clk_i) begin
      if (do_put)
         mem[wr_ptr] <= wr.beat;
   end

   assign rd.head         = mem[rd_ptr]; // Fall-through read
   assign rd.empty        = empty_r;
   assign rd.almost_empty = almost_empty_r;
   assign wr.full         = full_r;
   assign wr.almost_full  = almost_full_r;
   assign wr.half_full    = half_full_r;

   // Writer must watch the full flag
   a_no_put_when_full: assert property (
      @(posedge wb_clk_i) disable iff (!rst_n_i || clear_i)
      !(wr.put && wr.full)
   ) else $error("put on a full FIFO");

   // Reader must watch the empty flag
   a_no_get_when_empty: assert property (
      @(posedge wb_clk_i) disable iff (!rst_n_i || clear_i)
      !(rd.get && rd.empty)
   ) else $error("get on an empty FIFO");

endmodule

// File: hdl/chan_if.sv
// Read side of a FWFT FIFO
interface fifo_rd_if import dma_pkg::*; ();

   logic  get;          // Pop strobe
   beat_t head;         // Oldest entry, valid while not empty
   logic  empty;
   logic  almost_empty;

   modport fifo (
      input  get,
      output head, empty, almost_empty
   );

   modport reader (
      output get,
      input  head, empty, almost_empty
   );

endinterface

// Write side of a FIFO
interface fifo_wr_if import dma_pkg::*; ();

   logic  put;          // Push strobe
   beat_t beat;
   logic  full;
   logic  almost_full;
   logic  half_full;

   modport fifo (
      input  put, beat,
      output full, almost_full, half_full
   );

   modport writer (
      output put, beat,
      input  full, almost_full, half_full
   );

endinterface

// File: hdl/dma_chan_top.sv
module dma_chan_top import dma_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        rst_n_i,
   input  logic        m_reset_i,

   input  logic        ss_xfer0_i,
   input  logic        ss_last0_i,
   input  logic [31:0] wbs_dat_o0_i,
   input  logic [31:0] wbs_dat64_o0_i,
   output logic        ss_start0_o,
   output logic        ss_stop0_o,

   input  logic        ss_xfer1_i,
   output logic [31:0] wbs_dat_i1_o,
   output logic [31:0] wbs_dat64_i1_o,
   output logic        ss_start1_o,
   output logic        ss_stop1_o,
   output logic        ss_end1_o
);

   fifo_rd_if src_rd ();  // Source FIFO to the swap engine
   fifo_wr_if dst_wr ();  // Swap engine to the destination FIFO
   logic      pkt_end;

   dma_channel i_dma_channel (
      .wb_clk_i       (wb_clk_i),
      .rst_n_i        (rst_n_i),
      .m_reset_i      (m_reset_i),
      .ss_xfer0_i     (ss_xfer0_i),
      .ss_last0_i     (ss_last0_i),
      .wbs_dat_o0_i   (wbs_dat_o0_i),
      .wbs_dat64_o0_i (wbs_dat64_o0_i),
      .ss_start0_o    (ss_start0_o),
      .ss_stop0_o     (ss_stop0_o),
      .ss_xfer1_i     (ss_xfer1_i),
      .wbs_dat_i1_o   (wbs_dat_i1_o),
      .wbs_dat64_i1_o (wbs_dat64_i1_o),
      .ss_start1_o    (ss_start1_o),
      .ss_stop1_o     (ss_stop1_o),
      .ss_end1_o      (ss_end1_o),
      .src_rd         (src_rd),
      .dst_wr         (dst_wr),
      .pkt_end_i      (pkt_end)
   );

   byte_swap_stage i_byte_swap_stage (
      .wb_clk_i  (wb_clk_i),
      .rst_n_i   (rst_n_i),
      .m_reset_i (m_reset_i),
      .src_rd    (src_rd),
      .dst_wr    (dst_wr),
      .pkt_end_o (pkt_end)
   );

endmodule

// File: hdl/dma_channel.sv
`include "dma_params.svh"

module dma_channel import dma_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        rst_n_i,
   input  logic        m_reset_i,

   // Bus write side into the source FIFO
   input  logic        ss_xfer0_i,
   input  logic        ss_last0_i,
   input  logic [31:0] wbs_dat_o0_i,
   input  logic [31:0] wbs_dat64_o0_i,
   output logic        ss_start0_o,
   output logic        ss_stop0_o,

   // Bus read side out of the destination FIFO
   input  logic        ss_xfer1_i,
   output logic [31:0] wbs_dat_i1_o,
   output logic [31:0] wbs_dat64_i1_o,
   output logic        ss_start1_o,
   output logic        ss_stop1_o,
   output logic        ss_end1_o,

   // Engine side
   fifo_rd_if.fifo     src_rd,
   fifo_wr_if.fifo     dst_wr,
   input  logic        pkt_end_i
);

   fifo_wr_if src_wr ();
   fifo_rd_if dst_rd ();

   beat_t src_beat;
   beat_t dst_head;

   chan_fifo src_fifo (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .clear_i  (m_reset_i),
      .wr       (src_wr),
      .rd       (src_rd)
   );

   chan_fifo dst_fifo (
      .wb_clk_i (wb_clk_i),
      .rst_n_i  (rst_n_i),
      .clear_i  (m_reset_i),
      .wr       (dst_wr),
      .rd       (dst_rd)
   );

   // High word on top and last flag below the data
   assign src_beat   = '{data: {wbs_dat64_o0_i, wbs_dat_o0_i}, last: ss_last0_i};
   assign src_wr.put = ss_xfer0_i;
   assign src_wr.beat = src_beat;

   assign dst_rd.get     = ss_xfer1_i;
   assign dst_head       = dst_rd.head;
   assign wbs_dat64_i1_o = dst_head.data[`DMA_DATA_W-1 -: 32];
   assign wbs_dat_i1_o   = dst_head.data[31:0];

   // Write side flow
   assign ss_start0_o = !src_wr.half_full;
   assign ss_stop0_o  = src_wr.almost_full;

   // Read side flow where a packet end flushes a short tail
   assign ss_stop1_o  = dst_rd.almost_empty;
   assign ss_end1_o   = dst_head.last && !dst_rd.empty; // Head only counts when present
   assign ss_start1_o = dst_wr.half_full || (pkt_end_i && !dst_rd.empty);

endmodule

// File: hdl/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// FIFO geometry, 16 entries
`define DMA_FIFO_AW 4

// Beat payload width, high and low bus words
`define DMA_DATA_W 64

// Level thresholds on the fill count
`define DMA_ALMOST_FULL  14 // At or above
`define DMA_ALMOST_EMPTY 1  // At or below
`define DMA_HALF_FULL    8  // At or above

`endif

// File: hdl/dma_pkg.sv
`include "dma_params.svh"

package dma_pkg;

   // One FIFO entry, data word plus packet end
   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic                   last;
   } beat_t;

   // Read and write pointers wrap on their own
   typedef logic [`DMA_FIFO_AW-1:0] fifo_addr_t;

   // One extra bit so a full FIFO is distinct from an empty one
   typedef logic [`DMA_FIFO_AW:0] fifo_cnt_t;

endpackage

// File: sim/dma_chan_tests.txt
# W hi lo last | D count | F | C | B count | E start0 stop0 start1 stop1 end1
# Words in hex, counts and flags in decimal, a flag of 2 is not checked
E 1 0 0 1 0
W 00010203 04050607 0
W 08090a0b 0c0d0e0f 0
W 11223344 55667788 0
W deadbeef cafef00d 0
W a5a55a5a 0f1e2d3c 1
D 5
W 01020304 05060708 0
W 1111aaaa 2222bbbb 0
W fedcba98 76543210 1
F
D 3
B 31
D 31
W 13579bdf 2468ace0 0
W 89abcdef 01234567 1
C
E 1 0 0 1 2
W 0badf00d 600dcafe 1
F
D 1
E 1 0 0 1 2

// File: sim/tb_dma_chan.sv
module tb_dma_chan;
   timeunit 1ns;
   timeprecision 1ps;

   localparam TESTS_FILE = "sim/dma_chan_tests.txt";

   logic        clk;
   logic        rst_n;
   logic        m_reset;
   logic        xfer0;
   logic        last0;
   logic [31:0] dat_lo0;
   logic [31:0] dat_hi0;
   logic        start0;
   logic        stop0;
   logic        xfer1;
   logic [31:0] dat_lo1;
   logic [31:0] dat_hi1;
   logic        start1;
   logic        stop1;
   logic        end1;

   logic [63:0] exp_data[$]; // Byte-reversed words in write order
   logic        exp_last[$];
   int          seed = 30268;
   int          cycle_cnt = 0;
   int          cycle_limit = 0; // Zero until the tests file is sized

   dma_chan_top i_dma_chan_top (
      .wb_clk_i       (clk),
      .rst_n_i        (rst_n),
      .m_reset_i      (m_reset),
      .ss_xfer0_i     (xfer0),
      .ss_last0_i     (last0),
      .wbs_dat_o0_i   (dat_lo0),
      .wbs_dat64_o0_i (dat_hi0),
      .ss_start0_o    (start0),
      .ss_stop0_o     (stop0),
      .ss_xfer1_i     (xfer1),
      .wbs_dat_i1_o   (dat_lo1),
      .wbs_dat64_i1_o (dat_hi1),
      .ss_start1_o    (start1),
      .ss_stop1_o     (stop1),
      .ss_end1_o      (end1)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
         fail_run($sformatf("Timeout after %0d cycles", cycle_cnt));
   end

   // Eight bytes end for end
   function automatic logic [63:0] reverse_bytes(input logic [63:0] w);
      logic [63:0] r;
      for (int i = 0; i < 8; i++)
         r[8*i +: 8] = w[8*(7-i) +: 8];
      return r;
   endfunction

   task automatic write_word(input logic [31:0] hi, input logic [31:0] lo,
                             input logic last);
      @(negedge clk);
      while (stop0)
         @(negedge clk);
      @(posedge clk);
      xfer0   <= 1'b1;
      dat_hi0 <= hi;
      dat_lo0 <= lo;
      last0   <= last;
      @(posedge clk);
      xfer0   <= 1'b0;
      exp_data.push_back(reverse_bytes({hi, lo}));
      exp_last.push_back(last);
   endtask

   task automatic read_word();
      logic [63:0] exp_d;
      logic        exp_l;
      if (exp_data.size() == 0)
         fail_run("A read was requested but no word is expected");
      @(negedge clk);
      while (stop1 && !start1) // Readable only above almost empty or on a flush
         @(negedge clk);
      exp_d = exp_data.pop_front();
      exp_l = exp_last.pop_front();
      check_value("wbs_dat64_i1_o", 64'(dat_hi1), 64'(exp_d[63:32]));
      check_value("wbs_dat_i1_o", 64'(dat_lo1), 64'(exp_d[31:0]));
      check_value("ss_end1_o", 64'(end1), 64'(exp_l));
      @(posedge clk);
      xfer1 <= 1'b1;
      @(posedge clk);
      xfer1 <= 1'b0;
   endtask

   // Back-pressure fill with the last flag on the final word
   task automatic fill_random(input int n);
      logic [31:0] hi;
      logic [31:0] lo;
      int          k;
      for (int i = 0; i < n; i++) begin
         hi = $random(seed);
         lo = $random(seed);
         write_word(hi, lo, i == n - 1);
      end
      k = 0;
      @(negedge clk);
      while (!stop0 && k < 20) begin
         @(negedge clk);
         k++;
      end
      check_value("ss_stop0_o", 64'(stop0), 64'd1);
      // Source above half full and destination full
      check_value("ss_start0_o", 64'(start0), 64'd0);
      check_value("ss_stop1_o", 64'(stop1), 64'd0);
      check_value("ss_start1_o", 64'(start1), 64'd1);
   endtask

   task automatic wait_flush();
      int k;
      k = 0;
      @(negedge clk);
      while (!start1 && k < 50) begin
         @(negedge clk);
         k++;
      end
      check_value("ss_start1_o", 64'(start1), 64'd1);
   endtask

   task automatic pulse_clear();
      @(posedge clk);
      m_reset <= 1'b1;
      @(posedge clk);
      m_reset <= 1'b0;
      exp_data.delete();
      exp_last.delete();
   endtask

   task automatic expect_flags(input int s0, input int p0, input int s1, input int p1,
                               input int e1);
      @(posedge clk);
      @(negedge clk);
      if (s0 != 2) check_value("ss_start0_o", 64'(start0), 64'(s0));
      if (p0 != 2) check_value("ss_stop0_o", 64'(stop0), 64'(p0));
      if (s1 != 2) check_value("ss_start1_o", 64'(start1), 64'(s1));
      if (p1 != 2) check_value("ss_stop1_o", 64'(stop1), 64'(p1));
      if (e1 != 2) check_value("ss_end1_o", 64'(end1), 64'(e1));
   endtask

   // First pass only counts beats and the second runs the commands
   task automatic run_file(input bit run, output int beats);
      int               fd;
      int               code;
      int               a, b, c, d, e;
      logic [63:0]      tok;
      logic [8*128-1:0] rest;
      logic [31:0]      hi;
      logic [31:0]      lo;
      beats = 0;
      fd = $fopen(TESTS_FILE, "r");
      if (fd == 0)
         fail_run("Could not open the tests file");
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", tok);
         if (code != 1)
            break;
         if (tok == "#") begin
            code = $fgets(rest, fd);
         end else if (tok == "W") begin
            code = $fscanf(fd, "%h %h %d", hi, lo, a);
            beats++;
            if (run) write_word(hi, lo, a[0]);
         end else if (tok == "D") begin
            code = $fscanf(fd, "%d", a);
            if (run) repeat (a) read_word();
         end else if (tok == "B") begin
            code = $fscanf(fd, "%d", a);
            beats += a;
            if (run) fill_random(a);
         end else if (tok == "E") begin
            code = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
            if (run) expect_flags(a, b, c, d, e);
         end else if (tok == "F") begin
            if (run) wait_flush();
         end else if (tok == "C") begin
            if (run) pulse_clear();
         end else begin
            fail_run("Unknown command in the tests file");
         end
      end
      $fclose(fd);
   endtask

   initial begin
      int beats;
      rst_n   = 1'b0;
      m_reset = 1'b0;
      xfer0   = 1'b0;
      last0   = 1'b0;
      dat_lo0 = '0;
      dat_hi0 = '0;
      xfer1   = 1'b0;
      run_file(1'b0, beats);
      cycle_limit = 50 * beats + 200;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      run_file(1'b1, beats);
      if (exp_data.size() != 0) begin
         fail_run("Words were written but never read back");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule
